// ==== eurorack_pkg.sv ====
/* Constants and types shared by the audio path.
   Sample width, TDM frame geometry, calibration tables and core opcodes.
   Every design module and the testbench import it. */
package eurorack_pkg;

    // Sample and TDM frame geometry
    localparam int SAMPLE_W   = 16;
    localparam int SLOT_BITS  = 32;
    localparam int N_SLOTS    = 4;
    localparam int FRAME_CLKS = 256;

    // Counter widths that follow from the frame geometry
    localparam int CNT_W      = $clog2(FRAME_CLKS);
    localparam int SLOT_CNT_W = $clog2(2 * SLOT_BITS);
    localparam int SLOT_IDX_W = $clog2(N_SLOTS);

    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
    localparam logic signed [SAMPLE_W-1:0] SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};

    // Calibration channels 0-3 are ADC inputs and 4-7 are DAC outputs
    localparam int N_CAL_CH   = 8;
    localparam int CH_W       = $clog2(N_CAL_CH);
    localparam int GAIN_W     = 10;
    localparam int GAIN_SHIFT = 8;
    localparam int PROD_W     = SAMPLE_W + GAIN_W + 2;
    localparam int SCALED_W   = PROD_W - GAIN_SHIFT;

    localparam logic signed [SAMPLE_W-1:0] CAL_OFFSET [N_CAL_CH] = '{
        16'sd120, -16'sd85, 16'sd40, -16'sd12, 16'sd0, 16'sd60, -16'sd30, 16'sd15
    };

    // Gain of 256 is unity
    localparam logic [GAIN_W-1:0] CAL_GAIN [N_CAL_CH] = '{
        10'd260, 10'd250, 10'd256, 10'd270, 10'd256, 10'd245, 10'd262, 10'd300
    };

    localparam int CRUSH_MASK_BITS = 12;

    typedef enum logic [1:0] {OP_MIRROR, OP_VCA, OP_BITCRUSH, OP_INVERT} core_op_t;

    typedef enum logic [1:0] {CAL_IDLE, CAL_RUN, CAL_DONE} cal_state_t;

endpackage

// ==== codec_tdm.sv ====
/* TDM serial link to the four-in, four-out audio codec.
   Generates bick and lrck, shifts ADC slots in and DAC slots out,
   and pulses sample_clk once per frame with fresh ADC words. */
`timescale 1ns/1ns

module codec_tdm import eurorack_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    output logic                       pdn,
    output logic                       bick,
    output logic                       lrck,
    output logic                       sdin1,
    input  logic                       sdout1,
    output logic                       sample_clk,
    output logic signed [SAMPLE_W-1:0] adc0, adc1, adc2, adc3,
    input  logic signed [SAMPLE_W-1:0] dac0, dac1, dac2, dac3
);

    logic [CNT_W-1:0]           cnt;
    logic [CNT_W-1:0]           pos;
    logic [CNT_W-1:0]           pos_next;
    logic [SLOT_IDX_W-1:0]      slot;
    logic [SLOT_IDX_W-1:0]      slot_next;
    logic [SLOT_CNT_W-2:0]      bit_idx;
    logic                       frame_end;
    logic [SAMPLE_W-1:0]        rx_sr;
    logic signed [SAMPLE_W-1:0] hold [N_SLOTS];
    logic [SAMPLE_W-1:0]        tx_sr;
    logic signed [SAMPLE_W-1:0] tx_word;
    logic signed [SAMPLE_W-1:0] dac_q1, dac_q2, dac_q3;

    // Frame position runs half a frame ahead of cnt, so reset lands in slot 2
    // with lrck low
    assign pos       = cnt + CNT_W'(FRAME_CLKS / 2);
    assign pos_next  = pos + CNT_W'(1);
    assign slot      = pos[CNT_W-1 -: SLOT_IDX_W];
    assign slot_next = pos_next[CNT_W-1 -: SLOT_IDX_W];
    assign bit_idx   = pos[SLOT_CNT_W-1:1];
    assign frame_end = (pos == '1);

    assign bick = cnt[0];
    assign lrck = ~pos[CNT_W-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt        <= '0;
            pdn        <= 1'b0;
            sample_clk <= 1'b0;
        end else begin
            cnt        <= cnt + CNT_W'(1);
            pdn        <= 1'b1;
            sample_clk <= frame_end;
        end
    end

    // Receive the top 16 bits of each slot on the clk edge that raises bick
    always_ff @(posedge clk) begin
        if (!bick && bit_idx < (SLOT_CNT_W-1)'(SAMPLE_W)) begin
            rx_sr <= {rx_sr[SAMPLE_W-2:0], sdout1};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < N_SLOTS; i++) begin
                hold[i] <= '0;
            end
            adc0 <= '0;
            adc1 <= '0;
            adc2 <= '0;
            adc3 <= '0;
        end else begin
            if (!bick && bit_idx == (SLOT_CNT_W-1)'(SAMPLE_W - 1)) begin
                hold[slot] <= {rx_sr[SAMPLE_W-2:0], sdout1};
            end
            // Publish the whole frame together with sample_clk
            if (frame_end) begin
                adc0 <= hold[0];
                adc1 <= hold[1];
                adc2 <= hold[2];
                adc3 <= hold[3];
            end
        end
    end

    // Slot 0 loads straight from dac0 at the frame boundary
    always_comb begin
        case (slot_next)
            2'd0:    tx_word = dac0;
            2'd1:    tx_word = dac_q1;
            2'd2:    tx_word = dac_q2;
            default: tx_word = dac_q3;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dac_q1 <= '0;
            dac_q2 <= '0;
            dac_q3 <= '0;
            tx_sr  <= '0;
            sdin1  <= 1'b0;
        end else begin
            if (frame_end) begin
                dac_q1 <= dac1;
                dac_q2 <= dac2;
                dac_q3 <= dac3;
            end
            // Next bit leaves on the edge that drops bick and zeros fill the slot tail
            if (bick) begin
                if (pos_next[SLOT_CNT_W-1:0] == '0) begin
                    sdin1 <= tx_word[SAMPLE_W-1];
                    tx_sr <= {tx_word[SAMPLE_W-2:0], 1'b0};
                end else begin
                    sdin1 <= tx_sr[SAMPLE_W-1];
                    tx_sr <= {tx_sr[SAMPLE_W-2:0], 1'b0};
                end
            end
        end
    end

endmodule

// ==== cal.sv ====
/* Offset and gain calibration for four inputs and four outputs.
   One multiplier is shared across the eight channels, one per cycle after
   sample_clk; all outputs change together with the cal_strobe pulse. */
`timescale 1ns/1ns

module cal import eurorack_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       sample_clk,
    input  logic signed [SAMPLE_W-1:0] in0, in1, in2, in3, in4, in5, in6, in7,
    output logic signed [SAMPLE_W-1:0] out0, out1, out2, out3, out4, out5, out6, out7,
    output logic                       cal_strobe
);

    cal_state_t                 state;
    logic [CH_W-1:0]            ch;
    logic signed [SAMPLE_W-1:0] snap [N_CAL_CH];
    logic signed [SAMPLE_W-1:0] shadow [N_CAL_CH];
    logic signed [SAMPLE_W:0]   diff;
    logic signed [PROD_W-1:0]   prod;
    logic signed [SCALED_W-1:0] scaled;
    logic signed [SAMPLE_W-1:0] result;

    // Datapath for the current channel
    always_comb begin
        diff   = {snap[ch][SAMPLE_W-1], snap[ch]}
               - {CAL_OFFSET[ch][SAMPLE_W-1], CAL_OFFSET[ch]};
        prod   = PROD_W'(diff) * PROD_W'($signed({1'b0, CAL_GAIN[ch]}));
        scaled = prod[PROD_W-1:GAIN_SHIFT];
        // Clamp when the headroom bits disagree with the sign
        if (!scaled[SCALED_W-1] && |scaled[SCALED_W-2:SAMPLE_W-1]) begin
            result = SAMPLE_MAX;
        end else if (scaled[SCALED_W-1] && !(&scaled[SCALED_W-2:SAMPLE_W-1])) begin
            result = SAMPLE_MIN;
        end else begin
            result = scaled[SAMPLE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= CAL_IDLE;
            ch         <= '0;
            cal_strobe <= 1'b0;
            out0       <= '0;
            out1       <= '0;
            out2       <= '0;
            out3       <= '0;
            out4       <= '0;
            out5       <= '0;
            out6       <= '0;
            out7       <= '0;
        end else begin
            cal_strobe <= 1'b0;
            case (state)
                CAL_IDLE: begin
                    if (sample_clk) begin
                        snap[0] <= in0;
                        snap[1] <= in1;
                        snap[2] <= in2;
                        snap[3] <= in3;
                        snap[4] <= in4;
                        snap[5] <= in5;
                        snap[6] <= in6;
                        snap[7] <= in7;
                        ch      <= '0;
                        state   <= CAL_RUN;
                    end
                end
                CAL_RUN: begin
                    shadow[ch] <= result;
                    ch         <= ch + CH_W'(1);
                    if (ch == CH_W'(N_CAL_CH - 1)) begin
                        state <= CAL_DONE;
                    end
                end
                CAL_DONE: begin
                    out0       <= shadow[0];
                    out1       <= shadow[1];
                    out2       <= shadow[2];
                    out3       <= shadow[3];
                    out4       <= shadow[4];
                    out5       <= shadow[5];
                    out6       <= shadow[6];
                    out7       <= shadow[7];
                    cal_strobe <= 1'b1;
                    state      <= CAL_IDLE;
                end
                default: state <= CAL_IDLE;
            endcase
        end
    end

endmodule

// ==== dsp_core.sv ====
/* Per-sample processing core for the four calibrated inputs.
   core_sel picks mirror, VCA, bitcrush or invert; results are
   registered on cal_strobe and hold for the rest of the frame. */
`timescale 1ns/1ns

module dsp_core import eurorack_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cal_strobe,
    input  core_op_t                   core_sel,
    input  logic signed [SAMPLE_W-1:0] in0, in1, in2, in3,
    output logic signed [SAMPLE_W-1:0] core0, core1, core2, core3
);

    logic signed [2*SAMPLE_W-1:0] vca01;
    logic signed [2*SAMPLE_W-1:0] vca23;
    logic signed [SAMPLE_W-1:0]   res [N_SLOTS];

    function automatic logic signed [SAMPLE_W-1:0] crush(input logic signed [SAMPLE_W-1:0] x);
        return {x[SAMPLE_W-1:CRUSH_MASK_BITS], {CRUSH_MASK_BITS{1'b0}}};
    endfunction

    // Negation where only the most negative value needs clamping
    function automatic logic signed [SAMPLE_W-1:0] neg_sat(input logic signed [SAMPLE_W-1:0] x);
        if (x == SAMPLE_MIN) begin
            return SAMPLE_MAX;
        end
        return -x;
    endfunction

    // Channels 1 and 3 act as control voltages in the Q1.15 products
    assign vca01 = (2*SAMPLE_W)'(in0) * (2*SAMPLE_W)'(in1);
    assign vca23 = (2*SAMPLE_W)'(in2) * (2*SAMPLE_W)'(in3);

    always_comb begin
        case (core_sel)
            OP_VCA: begin
                res[0] = vca01[2*SAMPLE_W-2:SAMPLE_W-1];
                res[1] = in1;
                res[2] = vca23[2*SAMPLE_W-2:SAMPLE_W-1];
                res[3] = in3;
            end
            OP_BITCRUSH: begin
                res[0] = crush(in0);
                res[1] = crush(in1);
                res[2] = crush(in2);
                res[3] = crush(in3);
            end
            OP_INVERT: begin
                res[0] = neg_sat(in0);
                res[1] = neg_sat(in1);
                res[2] = neg_sat(in2);
                res[3] = neg_sat(in3);
            end
            default: begin
                res[0] = in0;
                res[1] = in1;
                res[2] = in2;
                res[3] = in3;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            core0 <= '0;
            core1 <= '0;
            core2 <= '0;
            core3 <= '0;
        end else if (cal_strobe) begin
            core0 <= res[0];
            core1 <= res[1];
            core2 <= res[2];
            core3 <= res[3];
        end
    end

endmodule

// ==== eurorack_top.sv ====
/* Audio path top level: codec link, calibration and DSP core.
   ADC words are inverted here to undo the analog front end. */
`timescale 1ns/1ns

module eurorack_top import eurorack_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     sdout1,
    input  core_op_t core_sel,
    output logic     pdn,
    output logic     bick,
    output logic     lrck,
    output logic     sdin1
);

    logic sample_clk;
    logic cal_strobe;

    // Raw codec samples
    logic signed [SAMPLE_W-1:0] adc0, adc1, adc2, adc3;
    logic signed [SAMPLE_W-1:0] dac0, dac1, dac2, dac3;

    // Calibrated inputs and core results
    logic signed [SAMPLE_W-1:0] cal_in0, cal_in1, cal_in2, cal_in3;
    logic signed [SAMPLE_W-1:0] core0, core1, core2, core3;

    codec_tdm i_codec_tdm (
        .clk        (clk),
        .rst        (rst),
        .pdn        (pdn),
        .bick       (bick),
        .lrck       (lrck),
        .sdin1      (sdin1),
        .sdout1     (sdout1),
        .sample_clk (sample_clk),
        .adc0 (adc0), .adc1 (adc1), .adc2 (adc2), .adc3 (adc3),
        .dac0 (dac0), .dac1 (dac1), .dac2 (dac2), .dac3 (dac3)
    );

    cal i_cal (
        .clk        (clk),
        .rst        (rst),
        .sample_clk (sample_clk),
        // Bitwise inversion undoes the inverting analog front end
        .in0 (~adc0), .in1 (~adc1), .in2 (~adc2), .in3 (~adc3),
        .in4 (core0), .in5 (core1), .in6 (core2), .in7 (core3),
        .out0 (cal_in0), .out1 (cal_in1), .out2 (cal_in2), .out3 (cal_in3),
        .out4 (dac0), .out5 (dac1), .out6 (dac2), .out7 (dac3),
        .cal_strobe (cal_strobe)
    );

    dsp_core i_dsp_core (
        .clk        (clk),
        .rst        (rst),
        .cal_strobe (cal_strobe),
        .core_sel   (core_sel),
        .in0 (cal_in0), .in1 (cal_in1), .in2 (cal_in2), .in3 (cal_in3),
        .core0 (core0), .core1 (core1), .core2 (core2), .core3 (core3)
    );

endmodule

// ==== eurorack_checker.sv ====
/* Protocol and timing assertions for the audio path top level.
   Bound into eurorack_top from the testbench and reports through $error. */
`timescale 1ns/1ns

module eurorack_checker (
    input logic clk,
    input logic rst,
    input logic pdn,
    input logic bick,
    input logic lrck,
    input logic sdin1,
    input logic sample_clk,
    input logic cal_strobe
);

    // Codec stays powered down through reset and is released right after
    a_pdn_reset: assert property (@(posedge clk) rst |=> !pdn)
        else $error("pdn high during reset");
    a_pdn_release: assert property (@(posedge clk) !rst |=> pdn)
        else $error("pdn not released after reset");

    // Serial outputs start quiet
    a_idle_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !bick && !lrck && !sdin1 && !sample_clk && !cal_strobe)
        else $error("outputs not low after reset");

    a_bick_toggle: assert property (@(posedge clk) !rst |=> (bick != $past(bick)))
        else $error("bick did not toggle");

    // 256 clk frame, lrck high for the first half
    a_lrck_period: assert property (@(posedge clk) disable iff (rst)
        $rose(lrck) |-> ##128 $fell(lrck) ##128 $rose(lrck))
        else $error("lrck period or duty wrong");

    a_strobe_width: assert property (@(posedge clk) disable iff (rst)
        sample_clk |=> !sample_clk)
        else $error("sample_clk wider than one cycle");
    a_strobe_period: assert property (@(posedge clk) disable iff (rst)
        sample_clk |-> ##256 sample_clk)
        else $error("sample_clk missing in next frame");
    a_strobe_frame: assert property (@(posedge clk) disable iff (rst)
        sample_clk |-> $rose(lrck))
        else $error("sample_clk not at frame start");

    // Calibration latency is fixed
    a_cal_latency: assert property (@(posedge clk) disable iff (rst)
        sample_clk |-> ##10 cal_strobe)
        else $error("cal_strobe late or missing");
    a_cal_origin: assert property (@(posedge clk) disable iff (rst)
        cal_strobe |-> $past(sample_clk, 10))
        else $error("cal_strobe without sample_clk");

endmodule

// ==== tb_eurorack.sv ====
/* Testbench for the audio path that models the codec on the TDM link,
   feeds random and full-scale ADC frames and checks each DAC word
   against a reference built from the calibration and core rules. */
`timescale 1ns/1ns

module tb_eurorack import eurorack_pkg::*; ();

    localparam int N_FRAMES = 28;
    localparam int N_CHECKS = (N_FRAMES - 3) * N_SLOTS;
    localparam int TIMEOUT  = 40 * FRAME_CLKS;

    logic     clk = 1'b0;
    logic     rst;
    logic     sdout1;
    core_op_t core_sel;
    logic     pdn, bick, lrck, sdin1;

    int          seed;
    int          frame;
    int          tpos;
    int          checked = 0;
    logic        synced;
    logic        lrck_last;
    logic [15:0] rx_sr;
    logic [15:0] adc_words [64][N_SLOTS];
    core_op_t    sel_at [64];

    eurorack_top i_eurorack_top (
        .clk      (clk),
        .rst      (rst),
        .sdout1   (sdout1),
        .core_sel (core_sel),
        .pdn      (pdn),
        .bick     (bick),
        .lrck     (lrck),
        .sdin1    (sdin1)
    );

    bind eurorack_top eurorack_checker i_eurorack_checker (
        .clk (clk), .rst (rst), .pdn (pdn), .bick (bick), .lrck (lrck),
        .sdin1 (sdin1), .sample_clk (sample_clk), .cal_strobe (cal_strobe)
    );

    always #4 clk = ~clk;

    function automatic int s16(input int x);
        logic signed [15:0] t;
        t = x[15:0];
        return int'(t);
    endfunction

    // Offset, gain, shift by 8 and clamp
    function automatic int calib(input int x, input int ch);
        int p;
        p = (x - int'(CAL_OFFSET[ch])) * int'(CAL_GAIN[ch]);
        p = p >>> 8;
        if (p > 32767) return 32767;
        if (p < -32768) return -32768;
        return p;
    endfunction

    function automatic int core_ref(input core_op_t op, input int a [4], input int j);
        case (op)
            OP_VCA: begin
                if (j == 0) return s16((a[0] * a[1]) >>> 15);
                if (j == 2) return s16((a[2] * a[3]) >>> 15);
                return a[j];
            end
            OP_BITCRUSH: return (a[j] >>> 12) <<< 12;
            OP_INVERT:   return (a[j] == -32768) ? 32767 : -a[j];
            default:     return a[j];
        endcase
    endfunction

    // DAC word for slot j from ADC frame k, three frames later
    function automatic int expected_dac(input int k, input int j, input core_op_t op);
        int a [4];
        for (int i = 0; i < 4; i++) begin
            a[i] = calib(s16(int'(~adc_words[k][i])), i);
        end
        return calib(core_ref(op, a, j), 4 + j);
    endfunction

    function automatic core_op_t sched_op(input int f);
        if (f < 8) return OP_MIRROR;
        if (f < 14) return OP_VCA;
        if (f < 20) return OP_BITCRUSH;
        return OP_INVERT;
    endfunction

    function automatic string op_name(input core_op_t op);
        case (op)
            OP_VCA:      return "vca";
            OP_BITCRUSH: return "bitcrush";
            OP_INVERT:   return "invert";
            default:     return "mirror";
        endcase
    endfunction

    // Received DAC word against the reference for its frame and slot
    task automatic check_dac_word(input int f, input int slot, input logic [15:0] word);
        int exp_v;
        int got_v;
        exp_v = expected_dac(f - 3, slot, sel_at[f - 2]);
        got_v = s16(int'(word));
        assert (got_v == exp_v) begin
            checked = checked + 1;
        end else begin
            $display("** Error [%s] frame %0d slot %0d: expected %0d, actual %0d",
                     op_name(sel_at[f - 2]), f, slot, exp_v, got_v);
            $display("=== FAIL ===");
            $fatal(1, "DAC word mismatch");
        end
    endtask

    // Bits after the 16 sample bits of a slot must be zero
    task automatic check_padding(input int f, input int slot, input logic bit_v);
        assert (bit_v == 1'b0) else begin
            $display("** Error [padding] frame %0d slot %0d: expected 0, actual %b",
                     f, slot, bit_v);
            $display("=== FAIL ===");
            $fatal(1, "DAC slot padding not zero");
        end
    endtask

    // Codec model that follows the DUT frame position in tpos, found from lrck
    always @(posedge clk) begin
        int pn;
        int slot;
        int b;
        logic [15:0] word;
        if (rst) begin
            synced    = 1'b0;
            lrck_last = 1'b0;
            frame     = -1;
            tpos      = 0;
            rx_sr     = '0;
        end else begin
            if (synced) begin
                tpos = (tpos + 1) % FRAME_CLKS;
            end else if (lrck_last && !lrck) begin
                synced = 1'b1;
                tpos   = 128;
            end
            lrck_last = lrck;
            if (synced) begin
                if (tpos == 255) begin
                    frame = frame + 1;
                    for (int j = 0; j < N_SLOTS && frame < 64; j++) begin
                        // Full-scale frames of both polarities hit the clamps
                        if (frame % 6 == 4) begin
                            adc_words[frame][j] = j[0] ? 16'h8000 : 16'h7FFF;
                        end else if (frame % 6 == 5) begin
                            adc_words[frame][j] = j[0] ? 16'h7FFF : 16'h8000;
                        end else begin
                            adc_words[frame][j] = 16'($random(seed));
                        end
                    end
                end
                if (tpos == 20 && frame >= 0 && frame < 64) sel_at[frame] = core_sel;
                if (tpos == 128) core_sel <= sched_op(frame);
                if (tpos % 2 == 1) begin
                    // Present the next ADC bit on falling bick
                    pn   = (tpos + 1) % FRAME_CLKS;
                    slot = pn / 64;
                    b    = (pn % 64) / 2;
                    if (b < 16 && frame >= 0 && frame < 64) begin
                        sdout1 <= adc_words[frame][slot][15 - b];
                    end else begin
                        sdout1 <= 1'b0;
                    end
                end else begin
                    slot = tpos / 64;
                    b    = (tpos % 64) / 2;
                    if (b < 16) begin
                        word  = {rx_sr[14:0], sdin1};
                        rx_sr = word;
                        if (b == 15 && frame >= 3 && frame < N_FRAMES) begin
                            check_dac_word(frame, slot, word);
                        end
                    end else begin
                        check_padding(frame, slot, sdin1);
                    end
                end
            end
        end
    end

    initial begin
        int cyc;
        rst      = 1'b1;
        sdout1   = 1'b0;
        core_sel = OP_MIRROR;
        seed     = 32'h1945;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        cyc = 0;
        while (!pdn && cyc < 20) begin
            @(posedge clk);
            cyc++;
        end
        if (!pdn) begin
            $display("pdn stayed low after reset");
            $display("=== FAIL ===");
            $fatal(1, "no power-down release");
        end
        cyc = 0;
        while (checked < N_CHECKS && cyc < TIMEOUT) begin
            @(posedge clk);
            cyc++;
        end
        if (checked == N_CHECKS) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("timed out with %0d of %0d DAC words checked", checked, N_CHECKS);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

endmodule

// ==== all.f ====
eurorack_pkg.sv
codec_tdm.sv
cal.sv
dsp_core.sv
eurorack_top.sv
eurorack_checker.sv
tb_eurorack.sv

// ==== Makefile ====
# Verilator simulation of the audio path testbench

VERILATOR ?= verilator
TOP       ?= tb_eurorack
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "No result in log"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
